// ==== rtl/http_match_config.svh ====
`ifndef HTTP_MATCH_CONFIG_SVH
`define HTTP_MATCH_CONFIG_SVH

// Number of interleaved streams tracked by the counter
`define STREAM_CNT 64

// Stream number width, enough for STREAM_CNT streams
`define STREAM_ID_W 6

// Per-subsystem packet counter width
`define COUNT_W 16

// Matcher progress, 0 to PATTERN_LEN bytes matched
`define DFA_STATE_W 3

// Signature "HTTP/1." with the first character in the top byte
`define PATTERN_LEN 7
`define PATTERN_BYTES 56'h48_54_54_50_2f_31_2e

`endif

// ==== rtl/http_match_pkg.sv ====
`default_nettype none

`include "http_match_config.svh"

package http_match_pkg;

   // One data byte of a packet
   typedef logic [7:0] byte_t;

   // Stream number carried on every beat
   typedef logic [`STREAM_ID_W-1:0] stream_id_t;

   // Count of pattern bytes matched so far
   typedef logic [`DFA_STATE_W-1:0] dfa_state_t;

   // Packets with at least one match
   typedef logic [`COUNT_W-1:0] match_count_t;

   // Input beat, at most one of sop, eop and char_vld is set
   typedef struct packed {
      logic       sop;
      logic       eop;
      logic       char_vld;
      stream_id_t stream_id;
      byte_t      char_in;
   } pkt_beat_t;

   // Framer to context record, one cycle behind the beat
   typedef struct packed {
      logic       load_state;
      logic       new_stream_id;
      logic       enable;
      logic       eop;
      logic       char_vld;
      stream_id_t stream_id;
      byte_t      char_in;
   } ctx_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/pattern_dfa.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "http_match_config.svh"

module pattern_dfa (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire http_match_pkg::byte_t      char_in,
   input  wire logic                       char_vld,
   input  wire logic                       state_in_vld,
   input  wire http_match_pkg::dfa_state_t state_in,
   output http_match_pkg::dfa_state_t      state_out,
   output logic                            accept
);
   import http_match_pkg::*;

   // Signature bytes, first character in the top byte
   localparam logic [8*`PATTERN_LEN-1:0] pattern_bytes = `PATTERN_BYTES;

   // Progress value meaning the whole signature was seen
   localparam dfa_state_t accept_state = dfa_state_t'(`PATTERN_LEN);

   dfa_state_t state_q;
   dfa_state_t base_state;
   dfa_state_t next_state;

   // Pattern character at position idx, idx below PATTERN_LEN
   function automatic byte_t pattern_byte(input dfa_state_t idx);
      int unsigned pos;
      pos = `PATTERN_LEN - 1 - int'(idx);
      return pattern_bytes[8*pos +: 8];
   endfunction

   // A restored state takes over from the running one
   assign base_state = state_in_vld ? state_in : state_q;

   always_comb
   begin
      next_state = base_state;
      if (char_vld)
      begin
         // Extend the match while the byte fits the next position
         if ((base_state < accept_state) && (char_in == pattern_byte(base_state)))
         begin
            next_state = base_state + dfa_state_t'(1);
         end
         // No border in "HTTP/1.", so a miss restarts at 0 or 1
         else if (char_in == pattern_byte(dfa_state_t'(0)))
         begin
            next_state = dfa_state_t'(1);
         end
         else
         begin
            next_state = '0;
         end
      end
   end

   // Progress and accept both registered one cycle after the byte
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= '0;
         accept  <= 1'b0;
      end
      else
      begin
         state_q <= next_state;
         accept  <= char_vld && (next_state == accept_state);
      end
   end

   assign state_out = state_q;

endmodule

`default_nettype wire

// ==== rtl/packet_framer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "http_match_config.svh"

module packet_framer (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire http_match_pkg::pkt_beat_t  beat,
   input  wire logic                       cfg_wr,
   input  wire logic                       cfg_enable,
   input  wire http_match_pkg::stream_id_t cfg_stream_id,
   output http_match_pkg::ctx_cmd_t        cmd
);
   import http_match_pkg::*;

   // One bit per stream, set once the stream has opened a packet
   logic [`STREAM_CNT-1:0] seen_map;

   // Matching enable per stream
   logic [`STREAM_CNT-1:0] enable_tbl;

   // Registered control half of the command
   logic load_state_q;
   logic new_stream_q;
   logic enable_q;
   logic eop_q;
   logic char_vld_q;

   // Registered payload half of the command
   stream_id_t stream_id_q;
   byte_t      char_q;

   // Mark the stream as seen on its header beat
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen_map <= '0;
      end
      else if (beat.sop)
      begin
         seen_map[beat.stream_id] <= 1'b1;
      end
   end

   // Configuration strobe, only used between packets
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         enable_tbl <= '0;
      end
      else if (cfg_wr)
      begin
         enable_tbl[cfg_stream_id] <= cfg_enable;
      end
   end

   // Header beat becomes the restore command
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         load_state_q <= 1'b0;
         new_stream_q <= 1'b0;
         enable_q     <= 1'b0;
         eop_q        <= 1'b0;
         char_vld_q   <= 1'b0;
      end
      else
      begin
         load_state_q <= beat.sop;
         // New only when the seen bit is still clear
         new_stream_q <= beat.sop & ~seen_map[beat.stream_id];
         // Enable sampled at the header, held until the next header
         if (beat.sop)
         begin
            enable_q <= enable_tbl[beat.stream_id];
         end
         eop_q      <= beat.eop;
         char_vld_q <= beat.char_vld;
      end
   end

   // Data path, qualified by the control bits above
   always_ff @(posedge clk)
   begin
      stream_id_q <= beat.stream_id;
      char_q      <= beat.char_in;
   end

   // Pack into the record seen by the context
   always_comb
   begin
      cmd.load_state    = load_state_q;
      cmd.new_stream_id = new_stream_q;
      cmd.enable        = enable_q;
      cmd.eop           = eop_q;
      cmd.char_vld      = char_vld_q;
      cmd.stream_id     = stream_id_q;
      cmd.char_in       = char_q;
   end

endmodule

`default_nettype wire

// ==== rtl/stream_match_context.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "http_match_config.svh"

module stream_match_context (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire http_match_pkg::ctx_cmd_t cmd,
   output http_match_pkg::match_count_t  count,
   output logic                          fired
);
   import http_match_pkg::*;

   // Saved progress, one entry per stream
   dfa_state_t state_mem [`STREAM_CNT];

   // Restore path into the matcher
   dfa_state_t state_in;
   logic       state_in_vld;

   // Matcher results
   dfa_state_t state_out;
   logic       accept;

   // Set once the current packet has matched
   logic match_flag;

   // End of packet one cycle late, lets the last accept land first
   logic       eop_d;
   logic       enable_d;
   stream_id_t eop_id_d;

   // Restore valid one cycle after the command
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
      end
      else
      begin
         state_in_vld <= cmd.load_state;
      end
   end

   // New streams start from zero, others from their saved entry
   always_ff @(posedge clk)
   begin
      if (cmd.load_state)
      begin
         if (cmd.new_stream_id)
         begin
            state_in <= '0;
         end
         else
         begin
            state_in <= state_mem[cmd.stream_id];
         end
      end
   end

   // Delayed trailer with its stream and enable
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         eop_d    <= 1'b0;
         enable_d <= 1'b0;
      end
      else
      begin
         eop_d    <= cmd.eop;
         enable_d <= cmd.enable;
      end
   end

   always_ff @(posedge clk)
   begin
      eop_id_d <= cmd.stream_id;
   end

   // Save progress only for enabled streams
   always_ff @(posedge clk)
   begin
      if (eop_d && enable_d)
      begin
         state_mem[eop_id_d] <= state_out;
      end
   end

   // Match flag and packet counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count      <= '0;
         match_flag <= 1'b0;
      end
      else
      begin
         // Flag is per packet, cleared when the next one opens
         if (cmd.load_state)
         begin
            match_flag <= 1'b0;
         end
         else if (accept)
         begin
            match_flag <= 1'b1;
         end
         // Finalize at the delayed end of packet
         if (eop_d)
         begin
            if (enable_d)
            begin
               count <= count + match_count_t'(match_flag);
            end
            else
            begin
               match_flag <= 1'b0;
            end
         end
      end
   end

   assign fired = match_flag;

   pattern_dfa dfa_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (cmd.char_in),
      .char_vld     (cmd.char_vld),
      .state_in_vld (state_in_vld),
      .state_in     (state_in),
      .state_out    (state_out),
      .accept       (accept)
   );

endmodule

`default_nettype wire

// ==== rtl/http_match_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module http_match_top (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   // Packet beats, one every cycle
   input  wire http_match_pkg::pkt_beat_t  beat,
   // Enable table write, between packets only
   input  wire logic                       cfg_wr,
   input  wire http_match_pkg::stream_id_t cfg_stream_id,
   input  wire logic                       cfg_enable,
   // Packets matched on enabled streams
   output http_match_pkg::match_count_t    count,
   // High while the current packet has matched
   output logic                            fired
);
   import http_match_pkg::*;

   // Aligned command stream from framer to context
   ctx_cmd_t cmd;

   // Producer side, beats to restore commands
   packet_framer framer_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .beat          (beat),
      .cfg_wr        (cfg_wr),
      .cfg_enable    (cfg_enable),
      .cfg_stream_id (cfg_stream_id),
      .cmd           (cmd)
   );

   // Consumer side, per-stream state and counting
   stream_match_context context_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .cmd   (cmd),
      .count (count),
      .fired (fired)
   );

endmodule

`default_nettype wire

// ==== testbench/http_match_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module http_match_sva (
   input wire logic                         clk,
   input wire logic                         rst_n,
   input wire http_match_pkg::ctx_cmd_t     cmd,
   input wire logic                         state_in_vld,
   input wire logic                         eop_d,
   input wire http_match_pkg::match_count_t count,
   input wire logic                         fired
);
   import http_match_pkg::*;

   // Restore valid exactly one cycle behind the restore command
   assert property (@(posedge clk) disable iff (!rst_n)
      cmd.load_state |=> state_in_vld)
      else $error("state_in_vld missing after load_state");

   assert property (@(posedge clk) disable iff (!rst_n)
      state_in_vld |-> $past(cmd.load_state))
      else $error("state_in_vld without load_state");

   // Counter steps by one, right after the delayed trailer
   assert property (@(posedge clk) disable iff (!rst_n)
      (count != $past(count)) |->
         ((count == match_count_t'($past(count) + 1'b1)) && $past(eop_d)))
      else $error("count changed outside a packet end");

   // New packet always opens with the flag clear
   assert property (@(posedge clk) disable iff (!rst_n)
      cmd.load_state |=> !fired)
      else $error("fired still high after load_state");

endmodule

// Watch the context from inside
bind stream_match_context http_match_sva sva_inst (
   .clk          (clk),
   .rst_n        (rst_n),
   .cmd          (cmd),
   .state_in_vld (state_in_vld),
   .eop_d        (eop_d),
   .count        (count),
   .fired        (fired)
);

`default_nettype wire

// ==== testbench/http_match_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "http_match_config.svh"

module http_match_tb;
   import http_match_pkg::*;

   localparam logic [31:0] seed = 32'hdb67e626;
   localparam int pkts_per_phase = 300;
   // Header, 27 bytes each behind an idle, trailer, 3 idles and the widest gap
   localparam int max_pkt_cycles = 2 + 2 * 27 + 3 + 6;
   localparam int setup_cycles = 120;
   // Two phases at 8 ns per cycle and doubled for margin
   localparam longint timeout_ns =
      2 * 2 * (pkts_per_phase * max_pkt_cycles + setup_cycles) * 8;

   // Signature in wire order with the first character in the top byte
   localparam logic [8*`PATTERN_LEN-1:0] signature = "HTTP/1.";
   localparam dfa_state_t full_match = dfa_state_t'(`PATTERN_LEN);

   logic         clk;
   logic         rst_n;
   pkt_beat_t    beat;
   logic         cfg_wr;
   stream_id_t   cfg_stream_id;
   logic         cfg_enable;
   match_count_t count;
   logic         fired;

   logic [31:0] rng_state;

   // Reference model of the per-stream state
   // Saved progress survives reset like the DUT memory
   logic         seen_m     [`STREAM_CNT];
   logic         enable_m   [`STREAM_CNT];
   logic         saved_vld  [`STREAM_CNT];
   dfa_state_t   saved_prog [`STREAM_CNT];
   match_count_t exp_count;

   // Bytes of the packet being sent
   byte_t pkt_bytes [$];

   http_match_top http_match_top_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .beat          (beat),
      .cfg_wr        (cfg_wr),
      .cfg_stream_id (cfg_stream_id),
      .cfg_enable    (cfg_enable),
      .count         (count),
      .fired         (fired)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int unsigned next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Mostly a few hot streams, so a stream comes back with other packets in between
   function automatic stream_id_t pick_stream();
      if (next_rand() % 4 == 0)
      begin
         return stream_id_t'(next_rand() % `STREAM_CNT);
      end
      return stream_id_t'(next_rand() % 6);
   endfunction

   function automatic byte_t sig_char(input int idx);
      return signature[8*(`PATTERN_LEN-1-idx) +: 8];
   endfunction

   // Extend on the expected byte, else restart at 1 on 'H' or at 0
   function automatic dfa_state_t model_step(input dfa_state_t s, input byte_t b);
      if (s < full_match)
      begin
         if (b == sig_char(int'(s)))
         begin
            return s + dfa_state_t'(1);
         end
      end
      if (b == sig_char(0))
      begin
         return dfa_state_t'(1);
      end
      return dfa_state_t'(0);
   endfunction

   task automatic check_count(input match_count_t got, input match_count_t exp);
      if (got !== exp)
      begin
         $display("[ERROR] count got 0x%h expected 0x%h", got, exp);
         $display("Test FAILED");
         $fatal(1, "count mismatch");
      end
   endtask

   task automatic check_fired(input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[ERROR] fired got 0x%h expected 0x%h", got, exp);
         $display("Test FAILED");
         $fatal(1, "fired mismatch");
      end
   endtask

   task automatic drive_beat(input logic sop, input logic eop, input logic vld,
                             input stream_id_t id, input byte_t ch);
      pkt_beat_t b;
      b.sop       = sop;
      b.eop       = eop;
      b.char_vld  = vld;
      b.stream_id = id;
      b.char_in   = ch;
      @(posedge clk);
      beat   <= b;
      cfg_wr <= 1'b0;
   endtask

   // Idle beats carry a junk id and byte that the DUT must ignore
   task automatic drive_idle();
      drive_beat(1'b0, 1'b0, 1'b0, stream_id_t'(next_rand()), byte_t'(next_rand()));
   endtask

   task automatic write_cfg(input stream_id_t id, input logic en);
      @(posedge clk);
      beat          <= '0;
      cfg_wr        <= 1'b1;
      cfg_stream_id <= id;
      cfg_enable    <= en;
      enable_m[id]   = en;
   endtask

   // Reset for 3 cycles while the model forgets streams and enables
   task automatic apply_reset();
      @(posedge clk);
      rst_n  <= 1'b0;
      beat   <= '0;
      cfg_wr <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < `STREAM_CNT; i++)
      begin
         seen_m[i]   = 1'b0;
         enable_m[i] = 1'b0;
      end
      exp_count = '0;
      @(negedge clk);
      check_count(count, exp_count);
      check_fired(fired, 1'b0);
   endtask

   // Segments of full, partial and stray signature bytes
   task automatic build_packet(input dfa_state_t start, input logic start_known);
      int n_seg;
      int n_pre;
      int k;
      pkt_bytes.delete();
      // With unknown saved progress the first byte lands on 1 or 0 from any state
      if (!start_known)
      begin
         pkt_bytes.push_back((next_rand() % 2 == 0) ? sig_char(0) : byte_t'("x"));
      end
      // Often finish a signature split at the end of this stream's last packet
      else if ((start != '0) && (start < full_match) && (next_rand() % 2 == 0))
      begin
         for (k = int'(start); k < `PATTERN_LEN; k++)
            pkt_bytes.push_back(sig_char(k));
      end
      n_seg = int'(next_rand() % 4);
      for (int s = 0; s < n_seg; s++)
      begin
         case (next_rand() % 8)
            0, 1:
               for (k = 0; k < `PATTERN_LEN; k++)
                  pkt_bytes.push_back(sig_char(k));
            2, 3:
            begin
               // Prefix of 1 to 6 bytes, may be left open at the packet end
               n_pre = 1 + int'(next_rand() % 6);
               for (k = 0; k < n_pre; k++)
                  pkt_bytes.push_back(sig_char(k));
            end
            4:
               for (k = 1 + int'(next_rand() % 6); k < `PATTERN_LEN; k++)
                  pkt_bytes.push_back(sig_char(k));
            5, 6:
               pkt_bytes.push_back(sig_char(int'(next_rand() % 7)));
            default:
               pkt_bytes.push_back(byte_t'(next_rand()));
         endcase
      end
   endtask

   task automatic send_packet(input stream_id_t id);
      dfa_state_t prog;
      logic       known;
      logic       en;
      logic       matched;
      int         n_gap;
      // Starting progress as the framer and context should restore it
      if (!seen_m[id])
      begin
         prog       = '0;
         known      = 1'b1;
         seen_m[id] = 1'b1;
      end
      else if (saved_vld[id])
      begin
         prog  = saved_prog[id];
         known = 1'b1;
      end
      else
      begin
         prog  = '0;
         known = 1'b0;
      end
      en = enable_m[id];
      build_packet(prog, known);
      matched = 1'b0;
      foreach (pkt_bytes[i])
      begin
         prog = model_step(prog, pkt_bytes[i]);
         if (prog == full_match)
            matched = 1'b1;
      end
      // Count once per packet and save progress on enabled streams only
      if (en)
      begin
         if (matched)
            exp_count = exp_count + match_count_t'(1);
         saved_prog[id] = prog;
         saved_vld[id]  = 1'b1;
      end
      drive_beat(1'b1, 1'b0, 1'b0, id, byte_t'(next_rand()));
      foreach (pkt_bytes[i])
      begin
         if (next_rand() % 8 == 0)
            drive_idle();
         drive_beat(1'b0, 1'b0, 1'b1, id, pkt_bytes[i]);
      end
      drive_beat(1'b0, 1'b1, 1'b0, id, byte_t'(next_rand()));
      drive_idle();
      drive_idle();
      // Two cycles after the trailer the flag holds every accept of the packet
      @(negedge clk);
      check_fired(fired, matched);
      drive_idle();
      // By the third cycle the counter is final and disabled streams dropped their flag
      @(negedge clk);
      check_count(count, exp_count);
      check_fired(fired, en & matched);
      n_gap = int'(next_rand() % 3);
      repeat (n_gap) drive_idle();
      if (next_rand() % 2 == 0)
         write_cfg(pick_stream(), (next_rand() % 4) != 0);
   endtask

   initial
   begin
      rst_n         = 1'b0;
      beat          = '0;
      cfg_wr        = 1'b0;
      cfg_stream_id = '0;
      cfg_enable    = 1'b0;
      rng_state     = seed;
      exp_count     = '0;
      for (int i = 0; i < `STREAM_CNT; i++)
      begin
         seen_m[i]     = 1'b0;
         enable_m[i]   = 1'b0;
         saved_vld[i]  = 1'b0;
         saved_prog[i] = '0;
      end
      // Second pass resets with the state memory still full of old progress
      for (int phase = 0; phase < 2; phase++)
      begin
         apply_reset();
         repeat (40) write_cfg(pick_stream(), (next_rand() % 4) != 0);
         drive_idle();
         repeat (pkts_per_phase) send_packet(pick_stream());
      end
      $display("Test OK");
      $finish;
   end

   initial
   begin
      #(timeout_ns);
      $display("Watchdog expired before all packets were checked");
      $display("Test FAILED");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+rtl
rtl/http_match_pkg.sv
rtl/pattern_dfa.sv
rtl/packet_framer.sv
rtl/stream_match_context.sv
rtl/http_match_top.sv
testbench/http_match_sva.sv
testbench/http_match_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := http_match_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
